/* alu_ops_engine/alu_ops_control_fsm.sv */
// Output FIFO needs four free entries above prog_full to absorb the pops still in flight on pause
`default_nettype none

module alu_ops_control_fsm import alu_ops_pkg::*; #(
    parameter int DONE_HOLD_CYCLES = 5
) (
    input  logic ap_clk,
    input  logic areset_generator,
    input  logic start,
    input  logic in_empty,
    input  logic out_empty,
    input  logic out_prog_full,
    input  logic popped_done,
    input  logic in_flight,
    output logic pop,
    output logic load,
    output logic running,
    output logic engine_done
);

    engine_state_e               state;
    engine_state_e               state_next;
    logic [DONE_HOLD_CYCLES-1:0] hold_sr;
    logic                        holding;

    // ----------------------------------------------------------------------
    // Engine state machine
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= ENG_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ENG_IDLE: begin
                if (start) begin
                    state_next = ENG_LOAD;
                end
            end
            ENG_LOAD: begin
                state_next = ENG_RUN;
            end
            ENG_RUN: begin
                if (out_prog_full) begin
                    state_next = ENG_PAUSE;
                end
            end
            ENG_PAUSE: begin
                if (!out_prog_full) begin
                    state_next = ENG_RUN;
                end
            end
            default: begin
                state_next = ENG_IDLE;
            end
        endcase
        // Clearing start stops the engine from any state
        if (!start) begin
            state_next = ENG_IDLE;
        end
    end

    assign load    = (state == ENG_LOAD);
    assign running = (state != ENG_IDLE);

    // ----------------------------------------------------------------------
    // Done hold lets the accumulator clear before the next sequence
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator || load) begin
            hold_sr <= '0;
        end else begin
            hold_sr <= (hold_sr << 1) | DONE_HOLD_CYCLES'(popped_done);
        end
    end

    assign holding = |hold_sr;
    assign pop     = (state == ENG_RUN) & ~in_empty & ~holding;

    // Idle engine with nothing queued or in the pipeline
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            engine_done <= 1'b0;
        end else begin
            engine_done <= running & in_empty & out_empty & ~in_flight;
        end
    end

    // Done pulses only come from a packet popped here
    done_pulse_needs_pop: assert property (
        @(posedge ap_clk) disable iff (areset_generator) popped_done |-> pop
    );

endmodule

`default_nettype wire

/* alu_ops_engine/alu_ops_datapath.sv */
// Results leave three cycles after their pop and ACC or MAX rely on the done hold between sequences
`default_nettype none

module alu_ops_datapath import alu_ops_pkg::*; (
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 load,
    input  alu_op_t              alu_op,
    input  dest_t                dest,
    input  logic                 popped,
    input  data_t                pkt_data,
    input  seq_id_t              pkt_seq_id,
    input  seq_state_t           pkt_seq_state,
    output logic                 popped_done,
    output logic                 in_flight,
    output logic                 push,
    output logic [OUT_PKT_W-1:0] push_data
);

    alu_op_t    op_q;
    dest_t      dest_q;
    logic       reduce_mode;
    logic       seq_end;
    data_t      acc;
    data_t      acc_base;
    logic       s1_valid;
    data_t      s1_data;
    seq_id_t    s1_seq_id;
    seq_state_t s1_seq_state;
    logic       s2_valid;
    data_t      s2_data;
    seq_id_t    s2_seq_id;
    seq_state_t s2_seq_state;

    // Configuration taken once per run
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            op_q   <= ALU_PASS;
            dest_q <= '0;
        end else if (load) begin
            op_q   <= alu_op;
            dest_q <= dest;
        end
    end

    assign reduce_mode = (op_q == ALU_ACC) || (op_q == ALU_MAX);
    assign popped_done = popped & reduce_mode & (pkt_seq_state == SEQ_DONE);
    assign seq_end     = s2_valid & reduce_mode & (s2_seq_state == SEQ_DONE);
    assign in_flight   = s1_valid | s2_valid | push;

    // ----------------------------------------------------------------------
    // Accumulator, cleared in load and when a result is taken
    // ----------------------------------------------------------------------
    assign acc_base = (load || seq_end) ? '0 : acc;

    always_ff @(posedge ap_clk) begin
        if (!s1_valid) begin
            acc <= acc_base;
        end else begin
            case (op_q)
                ALU_ACC: acc <= acc_base + s1_data;
                ALU_MAX: acc <= (s1_data > acc_base) ? s1_data : acc_base;
                default: acc <= acc_base;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Valid pipeline
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            push     <= 1'b0;
        end else begin
            s1_valid <= popped;
            s2_valid <= s1_valid;
            // Pass emits everything, reductions only the done packet
            push     <= s2_valid & (~reduce_mode | (s2_seq_state == SEQ_DONE));
        end
    end

    // Metadata follows the valid bits
    always_ff @(posedge ap_clk) begin
        s1_data      <= pkt_data;
        s1_seq_id    <= pkt_seq_id;
        s1_seq_state <= pkt_seq_state;
        s2_data      <= s1_data;
        s2_seq_id    <= s1_seq_id;
        s2_seq_state <= s1_seq_state;
        push_data    <= {dest_q, reduce_mode ? acc : s2_data, s2_seq_id, s2_seq_state};
    end

endmodule

`default_nettype wire

/* common/alu_ops_pkg.sv */
// Field widths are fixed here and every FIFO word packs its fields from MSB in the order below
`default_nettype none

package alu_ops_pkg;

    // ----------------------------------------------------------------------
    // Packet fields
    // ----------------------------------------------------------------------
    typedef logic [31:0] data_t;
    typedef logic [7:0]  seq_id_t;
    typedef logic [7:0]  dest_t;
    typedef logic [1:0]  seq_state_t;

    localparam seq_state_t SEQ_START = 2'd0;
    localparam seq_state_t SEQ_BUSY  = 2'd1;
    localparam seq_state_t SEQ_DONE  = 2'd2;

    // Input word is data, id, state and output word puts dest on top
    localparam int IN_PKT_W  = $bits(data_t) + $bits(seq_id_t) + $bits(seq_state_t);
    localparam int OUT_PKT_W = IN_PKT_W + $bits(dest_t);

    // ----------------------------------------------------------------------
    // Operations
    // ----------------------------------------------------------------------
    typedef logic [1:0] alu_op_t;

    // Code 3 is unused and falls back to pass
    localparam alu_op_t ALU_PASS = 2'd0;
    localparam alu_op_t ALU_ACC  = 2'd1;
    localparam alu_op_t ALU_MAX  = 2'd2;

    // ----------------------------------------------------------------------
    // APB register map
    // ----------------------------------------------------------------------
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t REG_CONTROL = 8'h00;
    localparam apb_addr_t REG_CONFIG  = 8'h04;
    localparam apb_addr_t REG_STATUS  = 8'h08;

    // Engine control states
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_LOAD,
        ENG_RUN,
        ENG_PAUSE
    } engine_state_e;

endpackage

`default_nettype wire

/* flist.f */
common/alu_ops_pkg.sv
source/sync_fifo.sv
source/alu_ops_apb_regs.sv
alu_ops_engine/alu_ops_control_fsm.sv
alu_ops_engine/alu_ops_datapath.sv
source/alu_ops_engine_top.sv
testbench/tb_alu_ops_engine.sv

/* run_sim.sh */
#!/bin/sh
# Compiles the ALU operations engine and its testbench with Verilator and runs it.
# Exit status is nonzero when the build fails or the testbench stops with $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module tb_alu_ops_engine \
    --Mdir obj_dir -o sim_tb \
    -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished without errors"
exit 0

/* source/alu_ops_apb_regs.sv */
// Zero wait state APB slave and only the word offsets 0x00 0x04 0x08 decode
`default_nettype none

module alu_ops_apb_regs import alu_ops_pkg::*; (
    input  logic      ap_clk,
    input  logic      areset_generator,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      start,
    output alu_op_t   alu_op,
    output dest_t     dest,
    input  logic      engine_done,
    input  logic      running
);

    logic access;
    logic addr_hit;
    logic wr_en;

    // ----------------------------------------------------------------------
    // Access decode
    // ----------------------------------------------------------------------
    assign access   = psel & penable;
    assign addr_hit = (paddr == REG_CONTROL) || (paddr == REG_CONFIG) || (paddr == REG_STATUS);
    assign wr_en    = access & pwrite & addr_hit;

    assign pready  = 1'b1;
    assign pslverr = access & ~addr_hit;

    // Status is read only so a write there simply falls through
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            start  <= 1'b0;
            alu_op <= ALU_PASS;
            dest   <= '0;
        end else if (wr_en) begin
            case (paddr)
                REG_CONTROL: begin
                    start <= pwdata[0];
                end
                REG_CONFIG: begin
                    alu_op <= pwdata[1:0];
                    dest   <= pwdata[15:8];
                end
                default: begin
                end
            endcase
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_CONTROL: begin
                    prdata[0] = start;
                end
                REG_CONFIG: begin
                    prdata[1:0]  = alu_op;
                    prdata[15:8] = dest;
                end
                REG_STATUS: begin
                    prdata[0] = engine_done;
                    prdata[1] = running;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

    // Access phase only inside a selected transfer
    penable_needs_psel: assert property (
        @(posedge ap_clk) disable iff (areset_generator) penable |-> psel
    );

endmodule

`default_nettype wire

/* source/alu_ops_engine_top.sv */
// FIFO_DEPTH must be a power of two of at least 8 and PROG_THRESH at most FIFO_DEPTH minus 4
`default_nettype none

module alu_ops_engine_top import alu_ops_pkg::*; #(
    parameter int FIFO_DEPTH       = 16,
    parameter int PROG_THRESH      = 8,
    parameter int DONE_HOLD_CYCLES = 5
) (
    input  logic       ap_clk,
    input  logic       areset,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    input  apb_data_t  pwdata,
    output apb_data_t  prdata,
    output logic       pready,
    output logic       pslverr,
    input  logic       in_valid,
    output logic       in_ready,
    input  data_t      in_data,
    input  seq_id_t    in_seq_id,
    input  seq_state_t in_seq_state,
    output logic       out_valid,
    input  logic       out_ready,
    output data_t      out_data,
    output dest_t      out_dest,
    output seq_id_t    out_seq_id,
    output seq_state_t out_seq_state,
    output logic       engine_done
);

    logic                 areset_generator;
    logic                 start;
    alu_op_t              alu_op;
    dest_t                dest;
    logic                 running;
    logic                 pop;
    logic                 load;
    logic                 popped;
    logic                 popped_done;
    logic                 in_flight;
    logic                 in_full;
    logic                 in_empty;
    logic [IN_PKT_W-1:0]  in_head;
    logic                 out_push;
    logic [OUT_PKT_W-1:0] out_word;
    logic [OUT_PKT_W-1:0] out_head;
    logic                 out_empty;
    logic                 out_prog_full;

    // Registered global reset
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    assign in_ready  = ~in_full;
    assign out_valid = ~out_empty;
    assign popped    = pop & ~in_empty;

    assign {out_dest, out_data, out_seq_id, out_seq_state} = out_head;

    alu_ops_apb_regs apb_regs0 (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .alu_op(alu_op), .dest(dest),
        .engine_done(engine_done), .running(running)
    );

    // ----------------------------------------------------------------------
    // Stream FIFOs
    // ----------------------------------------------------------------------
    sync_fifo #(.WIDTH(IN_PKT_W), .DEPTH(FIFO_DEPTH), .PROG_THRESH(PROG_THRESH)) in_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .push(in_valid & in_ready), .push_data({in_data, in_seq_id, in_seq_state}),
        .pop(pop), .pop_data(in_head),
        .empty(in_empty), .full(in_full), .prog_full()
    );

    sync_fifo #(.WIDTH(OUT_PKT_W), .DEPTH(FIFO_DEPTH), .PROG_THRESH(PROG_THRESH)) out_fifo (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .push(out_push), .push_data(out_word),
        .pop(out_valid & out_ready), .pop_data(out_head),
        .empty(out_empty), .full(), .prog_full(out_prog_full)
    );

    alu_ops_control_fsm #(.DONE_HOLD_CYCLES(DONE_HOLD_CYCLES)) control_fsm0 (
        .ap_clk(ap_clk), .areset_generator(areset_generator), .start(start),
        .in_empty(in_empty), .out_empty(out_empty), .out_prog_full(out_prog_full),
        .popped_done(popped_done), .in_flight(in_flight),
        .pop(pop), .load(load), .running(running), .engine_done(engine_done)
    );

    // Input head splits back into its fields
    alu_ops_datapath datapath0 (
        .ap_clk(ap_clk), .areset_generator(areset_generator),
        .load(load), .alu_op(alu_op), .dest(dest), .popped(popped),
        .pkt_data(in_head[IN_PKT_W-1 -: $bits(data_t)]),
        .pkt_seq_id(in_head[$bits(seq_state_t) +: $bits(seq_id_t)]),
        .pkt_seq_state(in_head[$bits(seq_state_t)-1:0]),
        .popped_done(popped_done), .in_flight(in_flight),
        .push(out_push), .push_data(out_word)
    );

endmodule

`default_nettype wire

/* source/sync_fifo.sv */
// DEPTH must be a power of two and PROG_THRESH below DEPTH, flags read busy for one cycle after reset
`default_nettype none

module sync_fifo #(
    parameter int WIDTH       = 42,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic [AW:0]      count_next;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Head entry is always visible
    assign pop_data = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Pointers, occupancy and registered flags
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            empty     <= 1'b1;
            full      <= 1'b1;
            prog_full <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count_next;
            empty     <= (count_next == '0);
            full      <= (count_next == (AW+1)'(DEPTH));
            prog_full <= (count_next >= (AW+1)'(PROG_THRESH));
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Writer is expected to watch full or a prog_full margin
    no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(push && full)
    );

endmodule

`default_nettype wire

/* testbench/tb_alu_ops_engine.sv */
// Runs the top level with its default parameters and relies on concurrent assertions for all checks
`default_nettype none

module tb_alu_ops_engine import alu_ops_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH     = 16;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PASS_PACKETS   = 40;
    localparam int SEQUENCES      = 8;

    logic ap_clk, areset, psel, penable, pwrite, pready, pslverr;
    apb_addr_t paddr;
    apb_data_t pwdata, prdata;
    logic in_valid, in_ready, out_valid, out_ready, engine_done;
    data_t in_data, out_data;
    seq_id_t in_seq_id, out_seq_id;
    seq_state_t in_seq_state, out_seq_state;
    dest_t out_dest;

    // Expected output packets, packed as dest, data, id, state
    logic [OUT_PKT_W-1:0] exp_q[$];
    logic [31:0] lfsr;
    logic exp_valid, take_pending, hold_output, idle_check, check_read, exp_slverr;
    logic [1:0] ready_phase;
    data_t exp_data;
    dest_t exp_dest, cfg_dest;
    seq_id_t exp_id;
    seq_state_t exp_state;
    apb_data_t exp_prdata;

    alu_ops_engine_top #(.FIFO_DEPTH(FIFO_DEPTH), .PROG_THRESH(8), .DONE_HOLD_CYCLES(5)) dut0 (
        .ap_clk(ap_clk), .areset(areset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data), .in_seq_id(in_seq_id),
        .in_seq_state(in_seq_state), .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data), .out_dest(out_dest), .out_seq_id(out_seq_id),
        .out_seq_state(out_seq_state), .engine_done(engine_done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // ----------------------------------------------------------------------
    // Failure reporting and random numbers
    // ----------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_problem(input string msg);
        $display("%0t %s", $time, msg);
        stop_with_failure();
    endtask

    // Taps 32 22 2 1 with one step per bit
    function automatic logic [31:0] next_random(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    idle_out_valid: assert property (@(posedge ap_clk) disable iff (areset)
        idle_check |-> !out_valid) else report_mismatch("out_valid", 0, $sampled(out_valid));
    idle_engine_done: assert property (@(posedge ap_clk) disable iff (areset)
        idle_check |-> !engine_done) else report_mismatch("engine_done", 0, $sampled(engine_done));
    pslverr_matches: assert property (@(posedge ap_clk) disable iff (areset)
        pslverr == (psel && penable && exp_slverr))
        else report_mismatch("pslverr", $sampled(psel && penable && exp_slverr), $sampled(pslverr));
    prdata_matches: assert property (@(posedge ap_clk) disable iff (areset)
        (psel && penable && check_read) |-> (prdata == exp_prdata))
        else report_mismatch("prdata", $sampled(exp_prdata), $sampled(prdata));
    out_expected: assert property (@(posedge ap_clk) disable iff (areset)
        (out_valid && out_ready) |-> exp_valid)
        else report_problem("An output packet arrived that was not expected");
    out_data_matches: assert property (@(posedge ap_clk) disable iff (areset)
        (out_valid && out_ready) |-> (out_data == exp_data))
        else report_mismatch("out_data", $sampled(exp_data), $sampled(out_data));
    out_dest_matches: assert property (@(posedge ap_clk) disable iff (areset)
        (out_valid && out_ready) |-> (out_dest == exp_dest))
        else report_mismatch("out_dest", $sampled(exp_dest), $sampled(out_dest));
    out_id_matches: assert property (@(posedge ap_clk) disable iff (areset)
        (out_valid && out_ready) |-> (out_seq_id == exp_id))
        else report_mismatch("out_seq_id", $sampled(exp_id), $sampled(out_seq_id));
    out_state_matches: assert property (@(posedge ap_clk) disable iff (areset)
        (out_valid && out_ready) |-> (out_seq_state == exp_state))
        else report_mismatch("out_seq_state", $sampled(exp_state), $sampled(out_seq_state));

    // Output side drops ready one cycle in four unless held
    initial begin
        out_ready = 1'b0;
        take_pending = 1'b0;
        exp_valid = 1'b0;
        ready_phase = '0;
        forever begin
            @(negedge ap_clk);
            if (take_pending && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            ready_phase = ready_phase + 2'd1;
            out_ready = !hold_output && (ready_phase != 2'd3);
            take_pending = out_valid && out_ready;
            exp_valid = (exp_q.size() != 0);
            if (exp_valid) begin
                {exp_dest, exp_data, exp_id, exp_state} = exp_q[0];
            end
        end
    end

    // ----------------------------------------------------------------------
    // Bus and stream tasks entered on a falling edge
    // ----------------------------------------------------------------------
    task automatic apb_access(input apb_addr_t addr, input logic write, input apb_data_t data,
                              input logic check_data);
        int waited;
        waited = 0;
        psel = 1'b1;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        exp_prdata = data;
        @(negedge ap_clk);
        penable = 1'b1;
        check_read = !write && check_data;
        while (!pready) begin
            @(negedge ap_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) report_problem("APB access never completed");
        end
        @(negedge ap_clk);
        psel = 1'b0;
        penable = 1'b0;
        check_read = 1'b0;
    endtask

    task automatic send_packet(input data_t d, input seq_id_t id, input seq_state_t st,
                               input logic expect_out);
        int waited;
        waited = 0;
        if (expect_out) begin
            exp_q.push_back({cfg_dest, d, id, st});
        end
        in_valid = 1'b1;
        in_data = d;
        in_seq_id = id;
        in_seq_state = st;
        while (!in_ready) begin
            @(negedge ap_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) report_problem("Input stream never took a packet");
        end
        @(negedge ap_clk);
        in_valid = 1'b0;
    endtask

    // ACC sums with wrap and MAX keeps the largest word
    task automatic send_sequence(input alu_op_t op);
        seq_id_t id;
        data_t d, result;
        int len;
        id = seq_id_t'(next_random(8));
        len = 2 + int'(next_random(2));
        result = '0;
        for (int i = 0; i < len; i++) begin
            d = next_random(32);
            if (op == ALU_ACC) begin
                result = result + d;
            end else if (d > result) begin
                result = d;
            end
            send_packet(d, id, (i == len - 1) ? SEQ_DONE : ((i == 0) ? SEQ_START : SEQ_BUSY),
                        1'b0);
        end
        exp_q.push_back({cfg_dest, result, id, SEQ_DONE});
    endtask

    task automatic start_engine(input alu_op_t op);
        apb_data_t cfg;
        cfg_dest = dest_t'(next_random(8));
        cfg = {16'h0, cfg_dest, 6'h0, op};
        apb_access(REG_CONFIG, 1'b1, cfg, 1'b0);
        apb_access(REG_CONFIG, 1'b0, cfg, 1'b1);
        apb_access(REG_CONTROL, 1'b1, 32'h1, 1'b0);
    endtask

    task automatic drain_and_check_done();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || !engine_done) begin
            @(negedge ap_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) report_problem("Output did not drain to engine_done");
        end
        apb_access(REG_STATUS, 1'b0, 32'h3, 1'b1);
    endtask

    task automatic stop_engine();
        int waited;
        waited = 0;
        apb_access(REG_CONTROL, 1'b1, 32'h0, 1'b0);
        while (engine_done) begin
            @(negedge ap_clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) report_problem("engine_done stayed high after stop");
        end
        apb_access(REG_STATUS, 1'b0, 32'h0, 1'b1);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        int sent;
        logic stalled;
        lfsr = 32'hefc5eec7;
        areset = 1'b1;
        {psel, penable, pwrite, check_read, exp_slverr, idle_check} = '0;
        paddr = '0;
        pwdata = '0;
        exp_prdata = '0;
        {in_valid, in_data, in_seq_id, in_seq_state} = '0;
        hold_output = 1'b1;
        cfg_dest = '0;
        repeat (16) @(negedge ap_clk);
        areset = 1'b0;
        hold_output = 1'b0;
        repeat (2) @(negedge ap_clk);
        idle_check = 1'b1;

        // Register access and a bad address
        apb_access(REG_CONFIG, 1'b1, 32'h0000_5a02, 1'b0);
        apb_access(REG_CONFIG, 1'b0, 32'h0000_5a02, 1'b1);
        exp_slverr = 1'b1;
        apb_access(8'h10, 1'b1, 32'h0000_ff01, 1'b0);
        apb_access(8'h10, 1'b0, 32'h0, 1'b0);
        exp_slverr = 1'b0;
        apb_access(REG_CONFIG, 1'b0, 32'h0000_5a02, 1'b1);
        idle_check = 1'b0;

        start_engine(ALU_PASS);
        for (int i = 0; i < PASS_PACKETS; i++) begin
            send_packet(next_random(32), seq_id_t'(next_random(8)),
                        seq_state_t'(next_random(2)), 1'b1);
            if (next_random(1) != 0) @(negedge ap_clk);
        end
        drain_and_check_done();

        // Back-pressure until the input side stalls
        hold_output = 1'b1;
        stalled = 1'b0;
        sent = 0;
        while (!stalled) begin
            if (!in_ready) begin
                stalled = 1'b1;
            end else begin
                send_packet(next_random(32), seq_id_t'(sent), SEQ_BUSY, 1'b1);
                sent++;
                if (sent > 4 * FIFO_DEPTH) report_problem("in_ready never dropped");
            end
        end
        repeat (10) @(negedge ap_clk);
        hold_output = 1'b0;
        drain_and_check_done();
        stop_engine();

        start_engine(ALU_ACC);
        for (int i = 0; i < SEQUENCES; i++) send_sequence(ALU_ACC);
        drain_and_check_done();
        stop_engine();

        start_engine(ALU_MAX);
        for (int i = 0; i < SEQUENCES; i++) send_sequence(ALU_MAX);
        drain_and_check_done();
        stop_engine();

        if (exp_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_problem("Expected packets were still outstanding at the end");
        end
    end

endmodule

`default_nettype wire
